//--- project.f
source/eth_log_pkg.sv
source/eth_script_pkg.sv
source/eth_frame_tracker.sv
source/eth_script_unit.sv
source/eth_sync_fifo.sv
source/eth_frame_loop_extract.sv
source/eth_frame_logger.sv
verification/tb_eth_frame_logger.sv

//--- Bender.yml
package:
  name: eth_frame_logger

sources:
  - source/eth_log_pkg.sv
  - source/eth_script_pkg.sv
  - source/eth_frame_tracker.sv
  - source/eth_script_unit.sv
  - source/eth_sync_fifo.sv
  - source/eth_frame_loop_extract.sv
  - source/eth_frame_logger.sv
  - target: test
    files:
      - verification/tb_eth_frame_logger.sv

//--- verification/tb_eth_frame_logger.sv
`timescale 1ns/1ps

module tb_eth_frame_logger
	import eth_log_pkg::*;
	import eth_script_pkg::*;
();

	localparam int NUM_ENTRIES = 11;
	localparam int TIMEOUT = 2000;
	localparam int GAP = 8;

	typedef struct packed {
		logic [15:0]                len;
		logic [4*INSTR_WIDTH-1:0]   instr;
		logic                       en;
		logic                       stall;
	} entry_t;

	logic clk;
	logic rst_n;
	logic enable;
	logic [TIME_WIDTH-1:0] current_time;
	logic [7:0] in_data;
	logic in_valid;
	logic in_last;
	logic in_fcs_bad;
	logic cfg_wr;
	logic [SEL_WIDTH-1:0] cfg_sel;
	logic [INSTR_WIDTH-1:0] cfg_word;
	logic [LOG_WIDTH-1:0] frame_data;
	logic frame_valid;
	logic frame_ready;
	logic [CTL_WIDTH-1:0] ctl_data;
	logic ctl_valid;
	logic ctl_ready;
	logic [OVF_WIDTH-1:0] overflow_count;

	entry_t stim [NUM_ENTRIES];
	logic [7:0] frame_bytes [256];
	logic [31:0] rng_state;
	int errors;
	int checks;
	logic [OVF_WIDTH-1:0] exp_ovf;

	// Expected output streams, in arrival order
	logic [LOG_WIDTH-1:0] exp_words [$];
	logic [NUM_SCRIPTS-1:0] exp_matched [$];
	logic [SIZE_WIDTH-1:0] exp_size [$];
	logic [TIME_WIDTH-1:0] exp_time [$];
	bit exp_time_chk [$];

	// 0 logged, 1 not armed, 2 lost to a full frame FIFO
	int pred_mode;
	logic [NUM_SCRIPTS-1:0] pred_matched;
	logic [SIZE_WIDTH-1:0] pred_size;

	eth_frame_logger dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.enable         (enable),
		.current_time   (current_time),
		.in_data        (in_data),
		.in_valid       (in_valid),
		.in_last        (in_last),
		.in_fcs_bad     (in_fcs_bad),
		.cfg_wr         (cfg_wr),
		.cfg_sel        (cfg_sel),
		.cfg_word       (cfg_word),
		.frame_data     (frame_data),
		.frame_valid    (frame_valid),
		.frame_ready    (frame_ready),
		.ctl_data       (ctl_data),
		.ctl_valid      (ctl_valid),
		.ctl_ready      (ctl_ready),
		.overflow_count (overflow_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Free running timestamp
	initial begin
		current_time = '0;
		forever begin
			@(posedge clk);
			#1;
			current_time = current_time + 1'b1;
		end
	end

	function automatic logic [31:0] cmp_word(input int offset, input logic [7:0] value,
		input logic [7:0] mask);
		return {1'b0, 11'(offset), value, mask, 4'h0};
	endfunction

	function automatic logic [31:0] rng_word(input int start, input int stop);
		return {1'b1, 11'(start), 11'(stop), 9'h0};
	endfunction

	function automatic logic [7:0] lcg_byte();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[23:16];
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] time %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic set_entry(input int idx, input int len, input logic [31:0] w0, w1, w2, w3,
		input logic en, stall);
		stim[idx].len = 16'(len);
		stim[idx].instr = {w3, w2, w1, w0};
		stim[idx].en = en;
		stim[idx].stall = stall;
	endtask

	task automatic load_table();
		logic [31:0] off;
		logic [31:0] all;
		off = cmp_word(0, 8'hff, 8'h00);
		all = rng_word(0, 2047);
		set_entry(0, 20, rng_word(3, 12), off, off, off, 1'b1, 1'b0);
		// Script 0 hits at byte 5, script 1 can never hit
		set_entry(1, 24, cmp_word(5, 8'h00, 8'h00), cmp_word(9, 8'h10, 8'h0f), off, off,
			1'b1, 1'b0);
		set_entry(2, 16, off, off, off, off, 1'b1, 1'b0);
		set_entry(3, 12, all, off, off, off, 1'b0, 1'b0);
		set_entry(4, 12, all, off, off, off, 1'b0, 1'b0);
		// Frames of 8, 8, 8 and 6 words leave two free for the fifth frame
		for (int i = 5; i < 10; i++) begin
			set_entry(i, (i == 8) ? 48 : 64, all, off, off, off, 1'b1, 1'b1);
		end
		set_entry(10, 30, all, off, off, rng_word(4, 9), 1'b1, 1'b0);
	endtask

	task automatic predict(input entry_t e);
		logic [31:0] w;
		logic [NUM_SCRIPTS-1:0] hit;
		logic [NUM_SCRIPTS-1:0] m;
		logic [LOG_WIDTH-1:0] word;
		logic [LOG_WIDTH-1:0] words [$];
		logic cap;
		logic [7:0] b;
		int cnt;
		int free;
		hit = '0;
		m = '0;
		word = '0;
		cnt = 0;
		for (int p = 0; p < e.len; p++) begin
			b = frame_bytes[p];
			cap = 1'b0;
			for (int s = 0; s < NUM_SCRIPTS; s++) begin
				w = e.instr[s*INSTR_WIDTH +: INSTR_WIDTH];
				if (w[31]) begin
					m[s] = p >= w[30:20];
					cap = cap | (m[s] && p <= w[19:9]);
				end else begin
					if (p == w[30:20] && (b & w[11:4]) == w[19:12]) begin
						hit[s] = 1'b1;
					end
					m[s] = hit[s];
					cap = cap | hit[s];
				end
			end
			if (cap) begin
				word[8*(cnt%LOG_BYTES) +: 8] = b;
				cnt++;
				if (cnt % LOG_BYTES == 0) begin
					words.push_back(word);
					word = '0;
				end
			end
		end
		if (cnt % LOG_BYTES != 0) begin
			words.push_back(word);
		end
		pred_matched = m;
		pred_size = SIZE_WIDTH'(cnt);
		free = FRAME_FIFO_DEPTH - exp_words.size();
		if (!e.en || free == 0) begin
			pred_mode = 1;
			exp_ovf++;
		end else if (words.size() > free) begin
			// One held word gets in once the FIFO drains
			pred_mode = 2;
			exp_ovf++;
			for (int i = 0; i <= free; i++) begin
				exp_words.push_back(words[i]);
			end
			exp_matched.push_back('0);
			exp_size.push_back(SIZE_WIDTH'((cnt < (free + 1) * 8) ? cnt : (free + 1) * 8));
			exp_time.push_back('0);
			exp_time_chk.push_back(1'b0);
		end else begin
			pred_mode = 0;
			foreach (words[i]) begin
				exp_words.push_back(words[i]);
			end
		end
	endtask

	task automatic load_scripts(input logic [4*INSTR_WIDTH-1:0] instr);
		for (int s = 0; s < NUM_SCRIPTS; s++) begin
			@(posedge clk);
			#1;
			cfg_wr = 1'b1;
			cfg_sel = SEL_WIDTH'(s);
			cfg_word = instr[s*INSTR_WIDTH +: INSTR_WIDTH];
		end
		@(posedge clk);
		#1;
		cfg_wr = 1'b0;
	endtask

	task automatic send_frame(input int len, output logic [TIME_WIDTH-1:0] last_time);
		for (int p = 0; p < len; p++) begin
			@(posedge clk);
			#1;
			in_data = frame_bytes[p];
			in_valid = 1'b1;
			in_last = (p == len - 1);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_last = 1'b0;
		// Extractor takes this time stamp on the next edge
		@(negedge clk);
		last_time = current_time;
	endtask

	function automatic bit outputs_pending(input bit with_words);
		return exp_size.size() != 0 || (with_words && exp_words.size() != 0);
	endfunction

	task automatic wait_outputs(input bit with_words, input string what);
		int n;
		n = 0;
		while (outputs_pending(with_words) && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (outputs_pending(with_words)) begin
			errors++;
			$display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
		end
	endtask

	task automatic run_entry(input entry_t e);
		logic [TIME_WIDTH-1:0] t;
		@(posedge clk);
		#1;
		enable = e.en;
		frame_ready = ~e.stall;
		if (!e.stall) begin
			wait_outputs(1'b1, "outputs of earlier frames");
		end
		load_scripts(e.instr);
		for (int p = 0; p < e.len; p++) begin
			frame_bytes[p] = lcg_byte();
		end
		predict(e);
		send_frame(e.len, t);
		if (pred_mode == 0) begin
			exp_matched.push_back(pred_matched);
			exp_size.push_back(pred_size);
			exp_time.push_back(t);
			exp_time_chk.push_back(1'b1);
		end
		repeat (GAP) @(posedge clk);
		if (pred_mode == 0) begin
			wait_outputs(~e.stall, "ctl record of the frame");
		end
		@(negedge clk);
		check_value(overflow_count, exp_ovf, "overflow count");
	endtask

	always @(negedge clk) begin
		logic [TIME_WIDTH-1:0] t;
		logic chk;
		if (rst_n && frame_valid && frame_ready) begin
			if (exp_words.size() == 0) begin
				errors++;
				$display("Frame word %0h came out with none expected", frame_data);
			end else begin
				check_value(frame_data, exp_words.pop_front(), "frame word");
			end
		end
		if (rst_n && ctl_valid && ctl_ready) begin
			if (exp_size.size() == 0) begin
				errors++;
				$display("Ctl record %0h came out with none expected", ctl_data);
			end else begin
				check_value(ctl_data[CTL_WIDTH-1 -: NUM_SCRIPTS], exp_matched.pop_front(),
					"ctl matched bits");
				check_value(ctl_data[TIME_WIDTH +: SIZE_WIDTH], exp_size.pop_front(), "ctl size");
				t = exp_time.pop_front();
				chk = exp_time_chk.pop_front();
				if (chk) begin
					check_value(ctl_data[TIME_WIDTH-1:0], t, "ctl timestamp");
				end
			end
		end
	end

	initial begin
		errors = 0;
		checks = 0;
		exp_ovf = '0;
		rng_state = 32'd25;
		rst_n = 1'b0;
		enable = 1'b1;
		in_data = '0;
		in_valid = 1'b0;
		in_last = 1'b0;
		in_fcs_bad = 1'b0;
		cfg_wr = 1'b0;
		cfg_sel = '0;
		cfg_word = '0;
		frame_ready = 1'b1;
		ctl_ready = 1'b1;
		load_table();
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			run_entry(stim[i]);
		end
		@(posedge clk);
		#1;
		frame_ready = 1'b1;
		wait_outputs(1'b1, "the final drain");
		@(negedge clk);
		check_value(overflow_count, exp_ovf, "final overflow count");
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- source/eth_frame_logger.sv
`timescale 1ns/1ps

module eth_frame_logger
	import eth_log_pkg::*;
	import eth_script_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic [TIME_WIDTH-1:0]  current_time,
	input  logic [7:0]             in_data,
	input  logic                   in_valid,
	input  logic                   in_last,
	// Frame check is handled upstream
	input  logic                   in_fcs_bad,
	input  logic                   cfg_wr,
	input  logic [SEL_WIDTH-1:0]   cfg_sel,
	input  logic [INSTR_WIDTH-1:0] cfg_word,
	output logic [LOG_WIDTH-1:0]   frame_data,
	output logic                   frame_valid,
	input  logic                   frame_ready,
	output logic [CTL_WIDTH-1:0]   ctl_data,
	output logic                   ctl_valid,
	input  logic                   ctl_ready,
	output logic [OVF_WIDTH-1:0]   overflow_count
);

	logic [7:0] byte_data;
	logic byte_valid;
	logic byte_last;
	logic [POS_WIDTH-1:0] byte_pos;
	logic [NUM_SCRIPTS-1:0] match_flags;
	logic [NUM_SCRIPTS-1:0] capture_flags;
	logic [LOG_WIDTH-1:0] frame_wr_data;
	logic frame_wr_valid;
	logic frame_wr_ready;
	logic [CTL_WIDTH-1:0] ctl_wr_data;
	logic ctl_wr_valid;
	logic ctl_wr_ready;

	eth_frame_tracker u_tracker (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_data    (in_data),
		.in_valid   (in_valid),
		.in_last    (in_last),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.byte_last  (byte_last),
		.byte_pos   (byte_pos)
	);

	for (genvar i = 0; i < NUM_SCRIPTS; i++) begin : g_script
		eth_script_unit #(
			.UNIT_INDEX (i)
		) u_script (
			.clk          (clk),
			.rst_n        (rst_n),
			.cfg_wr       (cfg_wr),
			.cfg_sel      (cfg_sel),
			.cfg_word     (cfg_word),
			.byte_data    (byte_data),
			.byte_valid   (byte_valid),
			.byte_last    (byte_last),
			.byte_pos     (byte_pos),
			.match_flag   (match_flags[i]),
			.capture_flag (capture_flags[i])
		);
	end

	eth_frame_loop_extract u_extract (
		.clk            (clk),
		.rst_n          (rst_n),
		.enable         (enable),
		.current_time   (current_time),
		.byte_data      (byte_data),
		.byte_valid     (byte_valid),
		.byte_last      (byte_last),
		.match_flags    (match_flags),
		.capture_flags  (capture_flags),
		.frame_wr_data  (frame_wr_data),
		.frame_wr_valid (frame_wr_valid),
		.frame_wr_ready (frame_wr_ready),
		.ctl_wr_data    (ctl_wr_data),
		.ctl_wr_valid   (ctl_wr_valid),
		.ctl_wr_ready   (ctl_wr_ready),
		.overflow_count (overflow_count)
	);

	eth_sync_fifo #(
		.WIDTH (LOG_WIDTH),
		.DEPTH (FRAME_FIFO_DEPTH)
	) u_frame_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_data  (frame_wr_data),
		.wr_valid (frame_wr_valid),
		.wr_ready (frame_wr_ready),
		.rd_data  (frame_data),
		.rd_valid (frame_valid),
		.rd_ready (frame_ready)
	);

	eth_sync_fifo #(
		.WIDTH (CTL_WIDTH),
		.DEPTH (CTL_FIFO_DEPTH)
	) u_ctl_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_data  (ctl_wr_data),
		.wr_valid (ctl_wr_valid),
		.wr_ready (ctl_wr_ready),
		.rd_data  (ctl_data),
		.rd_valid (ctl_valid),
		.rd_ready (ctl_ready)
	);

endmodule

//--- source/eth_frame_loop_extract.sv
`timescale 1ns/1ps

module eth_frame_loop_extract
	import eth_log_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic [TIME_WIDTH-1:0]  current_time,
	input  logic [7:0]             byte_data,
	input  logic                   byte_valid,
	input  logic                   byte_last,
	input  logic [NUM_SCRIPTS-1:0] match_flags,
	input  logic [NUM_SCRIPTS-1:0] capture_flags,
	output logic [LOG_WIDTH-1:0]   frame_wr_data,
	output logic                   frame_wr_valid,
	input  logic                   frame_wr_ready,
	output logic [CTL_WIDTH-1:0]   ctl_wr_data,
	output logic                   ctl_wr_valid,
	input  logic                   ctl_wr_ready,
	output logic [OVF_WIDTH-1:0]   overflow_count
);

	extract_state_e state;
	logic in_frame;
	logic [SIZE_WIDTH-1:0] count;
	logic [LOG_WIDTH-1:0] word_q;
	logic [LOG_WIDTH-1:0] next_word;
	logic [$clog2(LOG_BYTES)-1:0] lane;
	logic capture;
	logic word_done;
	logic frame_gap;

	always_comb begin
		lane = count[$clog2(LOG_BYTES)-1:0];
		capture = |capture_flags;
		// Lanes above the current one are still zero
		next_word = word_q | (LOG_WIDTH'(byte_data) << (8 * lane));
		word_done = (lane == '1) || byte_last;
		// True when the next cycle falls between frames
		frame_gap = byte_valid ? byte_last : ~in_frame;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= wait_fifo;
			in_frame <= 1'b0;
			count <= '0;
			word_q <= '0;
			frame_wr_data <= '0;
			frame_wr_valid <= 1'b0;
			ctl_wr_data <= '0;
			ctl_wr_valid <= 1'b0;
			overflow_count <= '0;
		end else begin
			if (frame_wr_valid && frame_wr_ready) begin
				frame_wr_valid <= 1'b0;
			end
			if (ctl_wr_valid && ctl_wr_ready) begin
				ctl_wr_valid <= 1'b0;
			end
			if (byte_valid) begin
				in_frame <= ~byte_last;
			end

			case (state)
				wait_fifo: begin
					count <= '0;
					word_q <= '0;
					if (enable && frame_gap && frame_wr_ready && ctl_wr_ready) begin
						state <= write_frame;
					end
				end

				write_frame: begin
					if (byte_valid) begin
						if (capture) begin
							count <= count + 1'b1;
							if (word_done) begin
								frame_wr_data <= next_word;
								frame_wr_valid <= 1'b1;
								word_q <= '0;
								if (!frame_wr_ready) begin
									// Word held until the FIFO takes it
									state <= overflow;
									ctl_wr_data <= {{NUM_SCRIPTS{1'b0}}, count + 1'b1, current_time};
									if (byte_last) begin
										overflow_count <= overflow_count + 1'b1;
									end
								end else if (byte_last) begin
									state <= write_ctl;
									ctl_wr_data <= {match_flags, count + 1'b1, current_time};
									ctl_wr_valid <= 1'b1;
								end
							end else begin
								word_q <= next_word;
							end
						end else if (byte_last) begin
							state <= write_ctl;
							ctl_wr_data <= {match_flags, count, current_time};
							ctl_wr_valid <= 1'b1;
							// Flush a partial word
							if (lane != '0) begin
								frame_wr_data <= word_q;
								frame_wr_valid <= 1'b1;
								word_q <= '0;
							end
						end
					end else if (!in_frame && !enable) begin
						state <= wait_fifo;
					end
				end

				write_ctl: begin
					if (ctl_wr_valid && ctl_wr_ready) begin
						state <= wait_fifo;
					end
				end

				overflow: begin
					if (frame_wr_valid && frame_wr_ready) begin
						state <= write_ctl;
						ctl_wr_valid <= 1'b1;
					end
				end

				default: state <= wait_fifo;
			endcase

			// Frames ending outside write_frame are lost
			if (state != write_frame && byte_valid && byte_last) begin
				overflow_count <= overflow_count + 1'b1;
			end
		end
	end

endmodule

//--- source/eth_sync_fifo.sv
`timescale 1ns/1ps

module eth_sync_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             wr_valid,
	output logic             wr_ready,
	output logic [WIDTH-1:0] rd_data,
	output logic             rd_valid,
	input  logic             rd_ready
);

	localparam int PTR_WIDTH = $clog2(DEPTH);
	localparam int CNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic do_wr;
	logic do_rd;

	assign wr_ready = count != CNT_WIDTH'(DEPTH);
	assign rd_valid = count != '0;
	assign rd_data = mem[rd_ptr];
	assign do_wr = wr_valid & wr_ready;
	assign do_rd = rd_valid & rd_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_WIDTH'(do_wr) - CNT_WIDTH'(do_rd);
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

endmodule

//--- source/eth_script_unit.sv
`timescale 1ns/1ps

module eth_script_unit
	import eth_log_pkg::*;
	import eth_script_pkg::*;
#(
	parameter int UNIT_INDEX = 0
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cfg_wr,
	input  logic [SEL_WIDTH-1:0]   cfg_sel,
	input  logic [INSTR_WIDTH-1:0] cfg_word,
	input  logic [7:0]             byte_data,
	input  logic                   byte_valid,
	input  logic                   byte_last,
	input  logic [POS_WIDTH-1:0]   byte_pos,
	output logic                   match_flag,
	output logic                   capture_flag
);

	script_instr_u instr;
	logic matched_q;
	logic cmp_hit;
	logic past_start;
	logic in_range;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// Never matches until loaded
			instr.cmp <= '{kind: kind_compare, offset: '0, value: 8'hff, mask: 8'h00, spare: '0};
		end else if (cfg_wr && cfg_sel == SEL_WIDTH'(UNIT_INDEX)) begin
			instr <= cfg_word;
		end
	end

	always_comb begin
		cmp_hit = byte_valid && byte_pos == instr.cmp.offset &&
			(byte_data & instr.cmp.mask) == instr.cmp.value;
		past_start = byte_pos >= instr.rng.start;
		in_range = past_start && byte_pos <= instr.rng.stop;

		if (instr.cmp.kind == kind_range) begin
			match_flag = byte_valid & past_start;
			capture_flag = byte_valid & in_range;
		end else begin
			match_flag = byte_valid & (matched_q | cmp_hit);
			capture_flag = match_flag;
		end
	end

	// Compare hit holds until the frame ends
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			matched_q <= 1'b0;
		end else if (byte_valid) begin
			if (byte_last) begin
				matched_q <= 1'b0;
			end else if (cmp_hit) begin
				matched_q <= 1'b1;
			end
		end
	end

endmodule

//--- source/eth_frame_tracker.sv
`timescale 1ns/1ps

module eth_frame_tracker
	import eth_log_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [7:0]           in_data,
	input  logic                 in_valid,
	input  logic                 in_last,
	output logic [7:0]           byte_data,
	output logic                 byte_valid,
	output logic                 byte_last,
	output logic [POS_WIDTH-1:0] byte_pos
);

	// Position of the next byte to arrive
	logic [POS_WIDTH-1:0] pos_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_valid <= 1'b0;
			byte_last <= 1'b0;
			pos_cnt <= '0;
		end else begin
			byte_valid <= in_valid;
			byte_last <= in_valid & in_last;
			if (in_valid) begin
				if (in_last) begin
					pos_cnt <= '0;
				end else begin
					pos_cnt <= pos_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			byte_data <= in_data;
			byte_pos <= pos_cnt;
		end
	end

endmodule

//--- source/eth_script_pkg.sv
package eth_script_pkg;

	localparam int INSTR_WIDTH = 32;

	typedef enum logic {
		kind_compare = 1'b0,
		kind_range   = 1'b1
	} script_kind_e;

	typedef struct packed {
		script_kind_e kind;
		logic [10:0]  offset;
		logic [7:0]   value;
		logic [7:0]   mask;
		logic [3:0]   spare;
	} compare_instr_t;

	typedef struct packed {
		script_kind_e kind;
		logic [10:0]  start;
		logic [10:0]  stop;
		logic [8:0]   spare;
	} range_instr_t;

	// Kind bit is the MSB in both views
	typedef union packed {
		compare_instr_t cmp;
		range_instr_t   rng;
	} script_instr_u;

endpackage

//--- source/eth_log_pkg.sv
package eth_log_pkg;

	// Script loop size
	localparam int NUM_SCRIPTS = 4;
	localparam int SEL_WIDTH = $clog2(NUM_SCRIPTS);

	// Frame log words
	localparam int LOG_WIDTH = 64;
	localparam int LOG_BYTES = LOG_WIDTH / 8;

	localparam int SIZE_WIDTH = 16;
	localparam int TIME_WIDTH = 64;
	localparam int OVF_WIDTH = 64;
	localparam int POS_WIDTH = 11;

	// Control record is {matched, size, timestamp}
	localparam int CTL_WIDTH = NUM_SCRIPTS + SIZE_WIDTH + TIME_WIDTH;

	localparam int FRAME_FIFO_DEPTH = 32;
	localparam int CTL_FIFO_DEPTH = 8;

	typedef enum logic [1:0] {
		wait_fifo,
		write_frame,
		write_ctl,
		overflow
	} extract_state_e;

endpackage
